//--- hdl/tbu_pkg.sv
package tbu_pkg;

  // Trellis size
  localparam int NUM_STATES = 16;
  localparam int STATE_W = $clog2(NUM_STATES);  // 4 bits

  // Survivor memory ring
  localparam int S = 32;                        // Stages kept in the ring
  localparam int COL_W = $clog2(S);             // 5 bits

  // Traceback schedule
  localparam int X_MIN = 8;                     // Merge depth before a block is read
  localparam int B = X_MIN;                     // Stages decoded per block
  localparam int CNT_W = $clog2((X_MIN > B) ? X_MIN : B);

  // Pointer 1 runs half a period behind pointer 0
  localparam int PTR1_DELAY = B;

  // Step on which pointer 0 captures its first start column.
  // Its first READ block then lands exactly on stages B-1 down to 0
  localparam int FIRST_START = X_MIN + B - 1;

  typedef enum logic [1:0] {
    IDLE,        // Waiting for enough stages in memory
    TRACEBACK,   // Walking back so the survivor paths merge
    READ         // Walking back and emitting decisions
  } ptr_state_e;

endpackage

//--- hdl/survivor_mem.sv
module survivor_mem
  import tbu_pkg::*;
(
  input  wire                           clk,
  input  wire                           sys_rst,
  input  wire                           valid_in,
  input  wire [NUM_STATES*STATE_W-1:0]  prev_state,
  input  wire [NUM_STATES-1:0]          desc,
  input  wire [COL_W-1:0]               rd_col_0,
  input  wire [STATE_W-1:0]             rd_row_0,
  input  wire                           rd_en_0,
  input  wire [COL_W-1:0]               rd_col_1,
  input  wire [STATE_W-1:0]             rd_row_1,
  input  wire                           rd_en_1,
  output logic [COL_W-1:0]              wr_col,
  output logic [STATE_W-1:0]            rd_prev_0,
  output logic                          rd_desc_0,
  output logic [STATE_W-1:0]            rd_prev_1,
  output logic                          rd_desc_1
);

  logic [STATE_W-1:0]    mem_prev [S][NUM_STATES];  // Predecessor per column and state
  logic [NUM_STATES-1:0] mem_desc [S];              // Decision bits per column
  logic [COL_W-1:0]      col_new;

  // The ring fills downwards, so older stages sit at higher columns
  assign col_new = (wr_col == '0) ? COL_W'(S - 1) : wr_col - 1'b1;

  // wr_col always points at the newest column already stored
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      wr_col <= '0;
    end else if (valid_in) begin
      wr_col <= col_new;
    end
  end

  // Whole column written on each trellis step
  always_ff @(posedge clk) begin
    if (valid_in) begin
      for (int k = 0; k < NUM_STATES; k++) begin
        mem_prev[col_new][k] <= prev_state[k*STATE_W +: STATE_W];
      end
      mem_desc[col_new] <= desc;
    end
  end

  // Read ports hold their data until the owning pointer reads again
  always_ff @(posedge clk) begin
    if (rd_en_0) begin
      rd_prev_0 <= mem_prev[rd_col_0][rd_row_0];
      rd_desc_0 <= mem_desc[rd_col_0][rd_row_0];
    end
    if (rd_en_1) begin
      rd_prev_1 <= mem_prev[rd_col_1][rd_row_1];
      rd_desc_1 <= mem_desc[rd_col_1][rd_row_1];
    end
  end

endmodule

//--- hdl/traceback_ptr.sv
module traceback_ptr
  import tbu_pkg::*;
#(
  parameter int START_STEP = FIRST_START    // Step count at which this pointer first starts
) (
  input  wire                 clk,
  input  wire                 sys_rst,
  input  wire                 valid_in,
  input  wire [COL_W-1:0]     wr_col,
  input  wire [STATE_W-1:0]   start_row,
  input  wire [STATE_W-1:0]   rd_prev,
  input  wire                 rd_desc,
  output logic [COL_W-1:0]    rd_col,
  output logic [STATE_W-1:0]  rd_row,
  output logic                rd_en,
  output logic                bit_valid,
  output logic                bit_desc,
  output logic [STATE_W-1:0]  bit_state
);

  ptr_state_e                      state;
  logic [$clog2(START_STEP+1)-1:0] step_cnt;  // Steps seen while idle
  logic [CNT_W-1:0]                tb_cnt;
  logic [CNT_W-1:0]                rd_cnt;
  logic [COL_W-1:0]                col_q;     // Next column to read
  logic [COL_W-1:0]                col_older;
  logic [STATE_W-1:0]              row_q;     // Start row, then row of the last read
  logic                            first_q;   // Next read uses the captured start row
  logic                            emit_q;    // Last read belongs to a READ block
  logic                            capture;

  // A new walk begins on the idle exit step and on the first TRACEBACK step.
  // That step only latches the newest column and the start row; reads follow
  assign capture = ((state == IDLE) && (step_cnt == START_STEP)) ||
                   ((state == TRACEBACK) && (tb_cnt == '0));

  assign col_older = (col_q == COL_W'(S - 1)) ? '0 : col_q + 1'b1;  // One stage back in time

  assign rd_col = col_q;
  assign rd_row = first_q ? row_q : rd_prev;  // Follow the survivor path
  assign rd_en  = valid_in && (state != IDLE) && !capture;

  // Result of the previous read, newest stage first
  assign bit_valid = valid_in && emit_q;
  assign bit_desc  = rd_desc;
  assign bit_state = row_q;

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      state    <= IDLE;
      step_cnt <= '0;
      tb_cnt   <= '0;
      rd_cnt   <= '0;
      first_q  <= 1'b0;
      emit_q   <= 1'b0;
    end else if (valid_in) begin
      first_q <= capture;
      emit_q  <= (state == READ);
      case (state)
        IDLE: begin
          if (step_cnt == START_STEP) begin
            state  <= TRACEBACK;
            tb_cnt <= CNT_W'(1);              // Idle exit counts as the capture step
          end else begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
        TRACEBACK: begin
          if (tb_cnt == CNT_W'(X_MIN - 1)) begin
            state  <= READ;
            tb_cnt <= '0;
            rd_cnt <= '0;
          end else begin
            tb_cnt <= tb_cnt + 1'b1;
          end
        end
        READ: begin
          if (rd_cnt == CNT_W'(B - 1)) begin
            state  <= TRACEBACK;              // Restart at the newest column
            rd_cnt <= '0;
          end else begin
            rd_cnt <= rd_cnt + 1'b1;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Column and row walk
  always_ff @(posedge clk) begin
    if (valid_in) begin
      if (capture) begin
        col_q <= wr_col;                      // Newest stored stage
        row_q <= start_row;                   // Its state, from the current step
      end else if (rd_en) begin
        col_q <= col_older;
        row_q <= rd_row;
      end
    end
  end

endmodule

//--- hdl/lifo_reorder.sv
module lifo_reorder
  import tbu_pkg::*;
(
  input  wire                 clk,
  input  wire                 sys_rst,
  input  wire                 valid_in,
  input  wire                 bit_valid,
  input  wire                 bit_desc,
  input  wire [STATE_W-1:0]   bit_state,
  output logic                vit_desc,
  output logic [STATE_W-1:0]  last_state,
  output logic                valid_out
);

  logic               buf_desc  [2][B];
  logic [STATE_W-1:0] buf_state [2][B];
  logic               wr_bank;
  logic [CNT_W-1:0]   wr_idx;
  logic               rd_bank;
  logic [CNT_W-1:0]   rd_idx;
  logic [1:0]         bank_full;  // Bank holds a complete block
  logic               pop;

  // One pop per trellis step while a full bank is waiting
  assign pop = valid_in && bank_full[rd_bank];

  always_ff @(posedge clk) begin
    if (bit_valid) begin
      buf_desc[wr_bank][wr_idx]  <= bit_desc;
      buf_state[wr_bank][wr_idx] <= bit_state;
    end
    if (pop) begin
      vit_desc   <= buf_desc[rd_bank][rd_idx];
      last_state <= buf_state[rd_bank][rd_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (sys_rst) begin
      wr_bank   <= 1'b0;
      wr_idx    <= '0;
      rd_bank   <= 1'b0;
      rd_idx    <= CNT_W'(B - 1);
      bank_full <= '0;
      valid_out <= 1'b0;
    end else begin
      valid_out <= pop;

      // Readout runs backwards through the bank, so oldest stage first
      if (pop) begin
        if (rd_idx == '0) begin
          rd_idx             <= CNT_W'(B - 1);
          rd_bank            <= ~rd_bank;
          bank_full[rd_bank] <= 1'b0;
        end else begin
          rd_idx <= rd_idx - 1'b1;
        end
      end

      // Fill forwards, newest stage at index 0
      if (bit_valid) begin
        if (wr_idx == CNT_W'(B - 1)) begin
          wr_idx             <= '0;
          wr_bank            <= ~wr_bank;     // Hand the block over to readout
          bank_full[wr_bank] <= 1'b1;
        end else begin
          wr_idx <= wr_idx + 1'b1;
        end
      end
    end
  end

endmodule

//--- hdl/tbu_top.sv
module tbu_top
  import tbu_pkg::*;
(
  input  wire                           clk,
  input  wire                           sys_rst,
  input  wire                           valid_in,
  input  wire [NUM_STATES*STATE_W-1:0]  prev_state,
  input  wire [NUM_STATES-1:0]          desc,
  output logic                          vit_desc,
  output logic [STATE_W-1:0]            last_state,
  output logic                          valid_out
);

  logic [COL_W-1:0]   wr_col;
  logic [STATE_W-1:0] start_row;
  logic [COL_W-1:0]   rd_col_0;
  logic [COL_W-1:0]   rd_col_1;
  logic [STATE_W-1:0] rd_row_0;
  logic [STATE_W-1:0] rd_row_1;
  logic               rd_en_0;
  logic               rd_en_1;
  logic [STATE_W-1:0] rd_prev_0;
  logic [STATE_W-1:0] rd_prev_1;
  logic               rd_desc_0;
  logic               rd_desc_1;
  logic               bit_valid_0;
  logic               bit_valid_1;
  logic               bit_desc_0;
  logic               bit_desc_1;
  logic [STATE_W-1:0] bit_state_0;
  logic [STATE_W-1:0] bit_state_1;
  logic               bit_valid;
  logic               bit_desc;
  logic [STATE_W-1:0] bit_state;

  assign start_row = prev_state[STATE_W-1:0];  // Predecessor of state 0 starts each walk

  // Only one pointer is in READ at a time, so a plain priority mux is enough
  assign bit_valid = bit_valid_0 | bit_valid_1;
  assign bit_desc  = bit_valid_0 ? bit_desc_0 : bit_desc_1;
  assign bit_state = bit_valid_0 ? bit_state_0 : bit_state_1;

  survivor_mem u_mem (
    .clk(clk), .sys_rst(sys_rst), .valid_in(valid_in),
    .prev_state(prev_state), .desc(desc),
    .rd_col_0(rd_col_0), .rd_row_0(rd_row_0), .rd_en_0(rd_en_0),
    .rd_col_1(rd_col_1), .rd_row_1(rd_row_1), .rd_en_1(rd_en_1),
    .wr_col(wr_col),
    .rd_prev_0(rd_prev_0), .rd_desc_0(rd_desc_0),
    .rd_prev_1(rd_prev_1), .rd_desc_1(rd_desc_1)
  );

  traceback_ptr #(.START_STEP(FIRST_START)) ptr_0 (
    .clk(clk), .sys_rst(sys_rst), .valid_in(valid_in),
    .wr_col(wr_col), .start_row(start_row),
    .rd_prev(rd_prev_0), .rd_desc(rd_desc_0),
    .rd_col(rd_col_0), .rd_row(rd_row_0), .rd_en(rd_en_0),
    .bit_valid(bit_valid_0), .bit_desc(bit_desc_0), .bit_state(bit_state_0)
  );

  traceback_ptr #(.START_STEP(FIRST_START + PTR1_DELAY)) ptr_1 (
    .clk(clk), .sys_rst(sys_rst), .valid_in(valid_in),
    .wr_col(wr_col), .start_row(start_row),
    .rd_prev(rd_prev_1), .rd_desc(rd_desc_1),
    .rd_col(rd_col_1), .rd_row(rd_row_1), .rd_en(rd_en_1),
    .bit_valid(bit_valid_1), .bit_desc(bit_desc_1), .bit_state(bit_state_1)
  );

  lifo_reorder u_lifo (
    .clk(clk), .sys_rst(sys_rst), .valid_in(valid_in),
    .bit_valid(bit_valid), .bit_desc(bit_desc), .bit_state(bit_state),
    .vit_desc(vit_desc), .last_state(last_state), .valid_out(valid_out)
  );

endmodule

//--- dv/tb_clk_gen.sv
module tb_clk_gen #(
  parameter int PERIOD = 4  // Clock period in time units
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #(PERIOD / 2) clk = ~clk;

endmodule

//--- dv/tb_checker.sv
module tb_checker
  import tbu_pkg::*;
(
  input wire                clk,
  input wire                sys_rst,
  input wire                valid_in,
  input wire                vit_desc,
  input wire [STATE_W-1:0]  last_state,
  input wire                valid_out
);

  localparam int MAX_LEN = 256;

  logic               exp_bit   [MAX_LEN];  // Message bit per step
  logic [STATE_W-1:0] exp_state [MAX_LEN];  // True encoder state per step
  int                 case_idx = 0;
  int                 case_len = 0;
  int                 case_min = 0;
  int                 out_idx = 0;          // Outputs seen since the last reset
  int                 wr_cnt = 0;           // Trellis steps written since the last reset
  int                 total_out = 0;
  int                 mismatch_cnt = 0;
  int                 fail_cnt = 0;
  logic               rst_q = 1'b0;

  task automatic report_failure(input string msg);
    $display("error at time %0t: %s", $time, msg);
    fail_cnt++;
  endtask

  task automatic start_case(input int idx, input int len, input int min_out);
    case_idx = idx;
    case_len = len;
    case_min = min_out;
    out_idx  = 0;
  endtask

  task automatic add_step(input int t, input logic bit_val, input logic [STATE_W-1:0] st);
    exp_bit[t]   = bit_val;
    exp_state[t] = st;
  endtask

  task automatic finish_case();
    if (out_idx < case_min) begin
      report_failure($sformatf("case %0d timed out with only %0d outputs, expected at least %0d",
                               case_idx, out_idx, case_min));
    end else if (out_idx > case_len) begin
      report_failure($sformatf("case %0d gave %0d outputs for only %0d message steps",
                               case_idx, out_idx, case_len));
    end
  endtask

  task automatic print_summary(input int n_cases);
    $display("checker summary: %0d cases, %0d outputs, %0d mismatches, %0d other failures",
             n_cases, total_out, mismatch_cnt, fail_cnt);
  endtask

  // Sampled on the rising edge, so every value is the one from before the edge
  always @(posedge clk) begin
    if (rst_q) begin
      if (valid_out !== 1'b0) begin
        report_failure("valid_out is not low while reset is applied");
      end
    end else if (valid_out === 1'b1) begin
      total_out++;
      if (wr_cnt < FIRST_START + B) begin
        report_failure($sformatf("output appeared after only %0d trellis steps", wr_cnt));
      end else if (out_idx >= case_len) begin
        report_failure($sformatf("case %0d produced more outputs than message steps", case_idx));
      end else if (vit_desc !== exp_bit[out_idx] || last_state !== exp_state[out_idx]) begin
        $display("mismatch at time %0t: case %0d output %0d gave bit %b state %0d, expected %b %0d",
                 $time, case_idx, out_idx, vit_desc, last_state,
                 exp_bit[out_idx], exp_state[out_idx]);
        mismatch_cnt++;
      end
      out_idx++;
    end
    if (sys_rst) begin
      out_idx = 0;  // Count restarts at message bit 0
      wr_cnt  = 0;
    end else if (valid_in) begin
      wr_cnt++;
    end
    rst_q = sys_rst;
  end

endmodule

//--- dv/tb_top.sv
module tb_top
  import tbu_pkg::*;
();

  localparam int MAX_LEN     = 256;
  localparam int MAX_LINES   = 200;
  localparam int OUT_TIMEOUT = 200;  // Cycles allowed for the last outputs

  logic                          clk;
  logic                          sys_rst;
  logic                          valid_in;
  logic [NUM_STATES*STATE_W-1:0] prev_state;
  logic [NUM_STATES-1:0]         desc;
  logic                          vit_desc;
  logic [STATE_W-1:0]            last_state;
  logic                          valid_out;

  logic                          msg        [MAX_LEN];
  logic [STATE_W-1:0]            true_state [MAX_LEN];

  tb_clk_gen #(.PERIOD(4)) clk_gen (.clk(clk));

  tbu_top uut (
    .clk(clk), .sys_rst(sys_rst), .valid_in(valid_in),
    .prev_state(prev_state), .desc(desc),
    .vit_desc(vit_desc), .last_state(last_state), .valid_out(valid_out)
  );

  tb_checker chk (
    .clk(clk), .sys_rst(sys_rst), .valid_in(valid_in),
    .vit_desc(vit_desc), .last_state(last_state), .valid_out(valid_out)
  );

  task automatic apply_reset();
    @(negedge clk);
    sys_rst = 1'b1;
    for (int c = 0; c < 5; c++) begin
      valid_in = c[0] ? 1'b0 : 1'b1;  // Strobes under reset must not reach the output
      @(negedge clk);
    end
    sys_rst  = 1'b0;
    valid_in = 1'b0;
  endtask

  // Mode 0 all zeros, 1 alternating, 2 random
  task automatic build_message(input int mode, input int len);
    logic [STATE_W-1:0] st;
    logic [31:0]        rnd;
    st = '0;
    for (int t = 0; t < len; t++) begin
      rnd = $urandom();
      if (mode == 0) begin
        msg[t] = 1'b0;
      end else if (mode == 1) begin
        msg[t] = t[0];
      end else begin
        msg[t] = rnd[5];
      end
      st = {msg[t], st[STATE_W-1:1]};  // Newest bit enters at the top
      true_state[t] = st;
    end
  endtask

  task automatic drive_step(input int t, input int gap_mode);
    logic [STATE_W-1:0] prev_true;
    logic [31:0]        rnd;
    int                 gap;
    @(negedge clk);
    prev_true = '0;
    if (t > 0) begin
      prev_true = true_state[t-1];
    end
    for (int k = 0; k < NUM_STATES; k++) begin
      rnd = $urandom();
      if (k == int'(true_state[t]) || k == 0) begin
        prev_state[k*STATE_W +: STATE_W] = prev_true;
      end else begin
        prev_state[k*STATE_W +: STATE_W] = rnd[STATE_W-1:0];  // Decoy predecessor
      end
      desc[k] = (k == int'(true_state[t])) ? msg[t] : rnd[8];
    end
    valid_in = 1'b1;
    @(negedge clk);
    valid_in = 1'b0;
    rnd = $urandom();
    gap = (gap_mode == 0) ? 1 : 1 + int'(rnd[1:0]);  // 1 to 4 idle cycles
    repeat (gap - 1) @(negedge clk);
  endtask

  task automatic run_case(input int idx, input int mode, input int len, input int gap_mode,
                          input int min_out, input int rst_at);
    int waited;
    build_message(mode, len);
    chk.start_case(idx, len, min_out);
    for (int t = 0; t < len; t++) begin
      chk.add_step(t, msg[t], true_state[t]);
    end
    apply_reset();
    if (rst_at > 0) begin
      for (int t = 0; t < rst_at; t++) begin
        drive_step(t, gap_mode);
      end
      apply_reset();  // Cut short, then replay the whole message
    end
    for (int t = 0; t < len; t++) begin
      drive_step(t, gap_mode);
    end
    waited = 0;
    while (chk.out_idx < min_out && waited < OUT_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    chk.finish_case();
  endtask

  initial begin
    int          fd;
    int          code;
    int          n_cases;
    string       line;
    int          mode;
    int          len;
    int          gap_mode;
    int          min_out;
    int          rst_at;
    sys_rst    = 1'b1;
    valid_in   = 1'b0;
    prev_state = '0;
    desc       = '0;
    void'($urandom(41235));
    n_cases    = 0;
    fd = $fopen("dv/tbu_testdata.txt", "r");
    if (fd == 0) begin
      chk.report_failure("could not open the test data file dv/tbu_testdata.txt");
    end else begin
      for (int ln = 0; ln < MAX_LINES && !$feof(fd); ln++) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 0 && line[0] != "#") begin
          code = $sscanf(line, "%d %d %d %d %d", mode, len, gap_mode, min_out, rst_at);
          if (code == 5) begin
            if (len > MAX_LEN || rst_at >= len) begin
              chk.report_failure($sformatf("test data line %0d is out of range", ln + 1));
            end else begin
              run_case(n_cases, mode, len, gap_mode, min_out, rst_at);
              n_cases++;
            end
          end
        end
      end
      $fclose(fd);
      if (n_cases == 0) begin
        chk.report_failure("the test data file holds no test cases");
      end
    end
    chk.print_summary(n_cases);
    if (chk.mismatch_cnt == 0 && chk.fail_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- dv/tbu_testdata.txt
# msg_mode length gap_mode min_outputs reset_at
# msg_mode 0 zeros 1 alternating 2 random, gap_mode 0 one idle 1 random 1..4 idle, reset_at 0 none
0 60 0 28 0
1 60 0 28 0
2 80 0 48 0
2 80 1 48 0
0 64 1 32 0
1 72 1 40 0
2 120 0 88 0
2 120 1 88 0
2 100 0 68 50
1 90 1 58 40
2 33 0 1 0
2 32 0 0 0
0 40 1 8 0
2 200 1 168 0
2 160 0 128 0
1 48 0 16 0
2 96 1 64 70
2 150 1 118 0

//--- compile.f
hdl/tbu_pkg.sv
hdl/survivor_mem.sv
hdl/traceback_ptr.sv
hdl/lifo_reorder.sv
hdl/tbu_top.sv
dv/tb_clk_gen.sv
dv/tb_checker.sv
dv/tb_top.sv
